/* Bender.yml */
package:
  name: eee_imgproc

sources:
  - logic/imgproc_pkg.sv
  - logic/pixel_classify.sv
  - logic/colour_runs.sv
  - logic/frame_bounds.sv
  - logic/msg_writer.sv
  - logic/msg_fifo.sv
  - logic/csr_port.sv
  - logic/eee_imgproc.sv
  - target: simulation
    files:
      - test/imgproc_properties.sv
      - test/tb_eee_imgproc.sv

/* logic/colour_runs.sv */
// run filter and recolouring

`timescale 1ns/1ps

module colour_runs (
	input  logic clk,
	input  logic reset_n,
	input  logic advance,
	input  logic mode,
	input  logic cls_valid,
	input  imgproc_pkg::classed_t cls,
	output logic source_valid,
	output imgproc_pkg::pixel_t source_pix,
	output logic conf_valid,
	output imgproc_pkg::classed_t conf
);
	import imgproc_pkg::*;

	logic [RUN_W-1:0] run_cnt [NUM_COLOURS:1];
	logic confirmed;
	rgb_t mark_rgb;
	logic [7:0] grey;
	pixel_t out_pix;

	// count includes the current pixel, hence RUN_LEN-1 already seen
	always_comb begin
		confirmed = 1'b0;
		mark_rgb = '0;
		for (int c = 1; c <= NUM_COLOURS; c++) begin
			if (cls.hit == colour_e'(c) && run_cnt[c] >= RUN_W'(RUN_LEN - 1)) begin
				confirmed = 1'b1;
				mark_rgb = MARKERS[c];
			end
		end
	end

	// grey = g/2 + r/4 + b/4
	assign grey = {1'b0, cls.pix.rgb.g[7:1]} + {2'b0, cls.pix.rgb.r[7:2]}
		+ {2'b0, cls.pix.rgb.b[7:2]};

	always_comb begin
		out_pix = cls.pix;
		if (mode && cls.is_video && !cls.pix.sop)
			out_pix.rgb = confirmed ? mark_rgb : '{grey, grey, grey};
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			source_valid <= 1'b0;
			for (int c = 1; c <= NUM_COLOURS; c++)
				run_cnt[c] <= '0;
		end else if (advance) begin
			source_valid <= cls_valid;
			if (cls_valid) begin
				for (int c = 1; c <= NUM_COLOURS; c++) begin
					if (cls.pix.sop || cls.hit != colour_e'(c))
						run_cnt[c] <= '0;
					else if (run_cnt[c] != RUN_W'(RUN_LEN))
						run_cnt[c] <= run_cnt[c] + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			source_pix <= out_pix;
			conf <= cls;
			conf.hit <= confirmed ? cls.hit : NONE;
		end
	end

	// strobe for the word leaving at the source
	assign conf_valid = source_valid & advance;

endmodule

/* logic/csr_port.sv */
// register port

`timescale 1ns/1ps

module csr_port (
	input  logic clk,
	input  logic reset_n,
	input  logic s_chipselect,
	input  logic s_read,
	input  logic s_write,
	input  logic [2:0] s_address,
	input  logic [31:0] s_writedata,
	input  logic [31:0] head,
	input  logic [8:0] count,
	input  logic empty,
	output logic [31:0] s_readdata,
	output logic pop,
	output logic flush
);
	import imgproc_pkg::*;

	logic [7:0] status_reg;
	logic read_d;
	logic rd_req;

	assign rd_req = s_chipselect & s_read;

	// bit 4 is a write-only flush
	assign flush = s_chipselect & s_write & (s_address == STATUS) & s_writedata[4];

	// one pop per read access, on its first cycle
	assign pop = rd_req & ~read_d & ~empty & (s_address == MSG);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			status_reg <= '0;
			s_readdata <= '0;
			read_d <= 1'b0;
		end else begin
			read_d <= rd_req;
			if (s_chipselect && s_write && s_address == STATUS)
				status_reg <= s_writedata[7:0];
			if (rd_req) begin
				case (s_address)
					STATUS:  s_readdata <= {16'b0, count[7:0], status_reg[7:5], 1'b0,
						status_reg[3:0]};
					MSG:     s_readdata <= head;
					ID:      s_readdata <= CHIP_ID;
					default: s_readdata <= '0;
				endcase
			end
		end
	end

endmodule

/* logic/eee_imgproc.sv */
// colour ball detector top

`timescale 1ns/1ps

module eee_imgproc #(
	parameter int image_w = imgproc_pkg::IMAGE_W_DEF,
	parameter int image_h = imgproc_pkg::IMAGE_H_DEF,
	parameter int horizon = imgproc_pkg::HORIZON_DEF
) (
	input  logic clk,
	input  logic reset_n,
	input  logic mode,
	input  logic sink_valid,
	output logic sink_ready,
	input  imgproc_pkg::pixel_t sink_pix,
	output logic source_valid,
	input  logic source_ready,
	output imgproc_pkg::pixel_t source_pix,
	input  logic s_chipselect,
	input  logic s_read,
	input  logic s_write,
	input  logic [2:0] s_address,
	input  logic [31:0] s_writedata,
	output logic [31:0] s_readdata
);
	import imgproc_pkg::*;

	// a horizon past the last row would never see a pixel
	localparam int horizon_eff = (horizon < image_h) ? horizon : image_h - 1;

	logic advance;
	logic cls_valid, conf_valid, frame_done;
	classed_t cls, conf;
	spans_t spans;
	logic msg_wr;
	logic [31:0] msg_word, fifo_head;
	logic [8:0] fifo_count;
	logic fifo_empty, fifo_pop, fifo_flush;

	//////////////////////////////
	// stream path
	assign advance = source_ready;
	assign sink_ready = source_ready;

	pixel_classify #(.image_w(image_w)) i_pixel_classify (
		.clk, .reset_n, .advance, .sink_valid, .sink_pix, .cls_valid, .cls
	);

	colour_runs i_colour_runs (
		.clk, .reset_n, .advance, .mode, .cls_valid, .cls,
		.source_valid, .source_pix, .conf_valid, .conf
	);

	//////////////////////////////
	// message path
	frame_bounds #(.image_w(image_w), .horizon(horizon_eff)) i_frame_bounds (
		.clk, .reset_n, .conf_valid, .conf, .spans, .frame_done
	);

	msg_writer i_msg_writer (
		.clk, .reset_n, .frame_done, .spans, .fifo_count, .wr(msg_wr), .wr_word(msg_word)
	);

	msg_fifo i_msg_fifo (
		.clk, .reset_n, .flush(fifo_flush), .wr(msg_wr), .wr_word(msg_word), .rd(fifo_pop),
		.head(fifo_head), .count(fifo_count), .empty(fifo_empty)
	);

	csr_port i_csr_port (
		.clk, .reset_n, .s_chipselect, .s_read, .s_write, .s_address, .s_writedata,
		.head(fifo_head), .count(fifo_count), .empty(fifo_empty),
		.s_readdata, .pop(fifo_pop), .flush(fifo_flush)
	);

endmodule

/* logic/frame_bounds.sv */
// per-colour horizontal extent

`timescale 1ns/1ps

module frame_bounds #(
	parameter int image_w = imgproc_pkg::IMAGE_W_DEF,
	parameter int horizon = imgproc_pkg::HORIZON_DEF
) (
	input  logic clk,
	input  logic reset_n,
	input  logic conf_valid,
	input  imgproc_pkg::classed_t conf,
	output imgproc_pkg::spans_t spans,
	output logic frame_done
);
	import imgproc_pkg::*;

	localparam span_t EMPTY = '{x_min: COORD_W'(image_w - 1), x_max: '0};

	spans_t work, work_nx;

	always_comb begin
		work_nx = work;
		for (int c = 1; c <= NUM_COLOURS; c++) begin
			if (conf.pix.sop) begin
				work_nx[c] = EMPTY;
			end else if (conf.hit == colour_e'(c) && conf.y > COORD_W'(horizon)) begin
				if (conf.x < work[c].x_min)
					work_nx[c].x_min = conf.x;
				if (conf.x > work[c].x_max)
					work_nx[c].x_max = conf.x;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			work <= {NUM_COLOURS{EMPTY}};
			spans <= {NUM_COLOURS{EMPTY}};
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (conf_valid) begin
				work <= work_nx;
				// latch including the eop pixel itself
				if (conf.pix.eop && conf.is_video) begin
					spans <= work_nx;
					frame_done <= 1'b1;
				end
			end
		end
	end

endmodule

/* logic/imgproc_pkg.sv */
// image processing shared types
// and constants

package imgproc_pkg;

	localparam int PIX_W = 8;
	localparam int COORD_W = 11;
	localparam int IMAGE_W_DEF = 640;
	localparam int IMAGE_H_DEF = 480;
	localparam int HORIZON_DEF = 280;

	localparam int NUM_COLOURS = 3;
	localparam int RUN_LEN = 10;
	localparam int RUN_W = $clog2(RUN_LEN + 1);

	localparam int MSG_INTERVAL = 6;
	localparam int FRAME_W = $clog2(MSG_INTERVAL);
	localparam int FIFO_DEPTH = 256;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);
	localparam int MSG_ROOM = 4;
	localparam logic [31:0] MSG_HEADER = 32'h0052_4242;
	localparam logic [31:0] CHIP_ID = 32'h1234EEE2;

	//////////////////////////////
	// colour windows, hue in half degrees
	// a low bound above the high bound wraps through zero
	localparam int RED_HUE_LO = 172;
	localparam int RED_HUE_HI = 6;
	localparam int RED_SAT_MIN = 84;
	localparam int RED_VAL_MIN = 105;
	localparam int YEL_HUE_LO = 16;
	localparam int YEL_HUE_HI = 30;
	localparam int YEL_SAT_MIN = 127;
	localparam int YEL_VAL_MIN = 124;
	localparam int TEAL_HUE_LO = 53;
	localparam int TEAL_HUE_HI = 85;
	localparam int TEAL_SAT_MIN = 80;
	localparam int TEAL_VAL_MIN = 60;

	typedef enum logic [1:0] {NONE, RED, YELLOW, TEAL} colour_e;
	typedef enum logic [2:0] {IDLE, HEADER, WORD_RED, WORD_YELLOW, WORD_TEAL} msg_state_e;
	typedef enum logic [2:0] {STATUS = 3'd0, MSG = 3'd1, ID = 3'd2} csr_addr_e;

	typedef struct packed {
		logic [PIX_W-1:0] r;
		logic [PIX_W-1:0] g;
		logic [PIX_W-1:0] b;
	} rgb_t;

	typedef struct packed {
		rgb_t rgb;
		logic sop;
		logic eop;
	} pixel_t;

	typedef struct packed {
		pixel_t pix;
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
		logic is_video;
		colour_e hit;
	} classed_t;

	typedef struct packed {
		logic [COORD_W-1:0] x_min;
		logic [COORD_W-1:0] x_max;
	} span_t;

	// indexed by colour_e, NONE has no slot
	typedef span_t [NUM_COLOURS:1] spans_t;

	// marker colours, index 3 (teal) in the top bits
	localparam rgb_t [NUM_COLOURS:1] MARKERS = {24'h008080, 24'hffff00, 24'hff1000};

endpackage

/* logic/msg_fifo.sv */
// message FIFO

`timescale 1ns/1ps

module msg_fifo (
	input  logic clk,
	input  logic reset_n,
	input  logic flush,
	input  logic wr,
	input  logic [31:0] wr_word,
	input  logic rd,
	output logic [31:0] head,
	output logic [8:0] count,
	output logic empty
);
	import imgproc_pkg::*;

	logic [31:0] mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wptr, rptr;
	logic do_wr, do_rd;

	assign do_wr = wr && (count != 9'(FIFO_DEPTH));
	assign do_rd = rd && !empty;

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wptr] <= wr_word;
	end

	always_ff @(posedge clk) begin
		if (!reset_n || flush) begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wptr <= wptr + 1'b1;
			if (do_rd)
				rptr <= rptr + 1'b1;
			count <= count + 9'(do_wr) - 9'(do_rd);
		end
	end

	// show-ahead head word
	assign head = mem[rptr];
	assign empty = (count == '0);

endmodule

/* logic/msg_writer.sv */
// message writer FSM

`timescale 1ns/1ps

module msg_writer (
	input  logic clk,
	input  logic reset_n,
	input  logic frame_done,
	input  imgproc_pkg::spans_t spans,
	input  logic [8:0] fifo_count,
	output logic wr,
	output logic [31:0] wr_word
);
	import imgproc_pkg::*;

	msg_state_e state;
	logic [FRAME_W-1:0] frame_cnt;
	logic start;

	function automatic logic [31:0] span_word(input span_t s);
		return {5'b0, s.x_min, 5'b0, s.x_max};
	endfunction

	assign start = frame_done && state == IDLE && frame_cnt == '0
		&& fifo_count <= 9'(FIFO_DEPTH - MSG_ROOM);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IDLE;
			frame_cnt <= '0;
		end else begin
			if (start)
				frame_cnt <= FRAME_W'(MSG_INTERVAL - 1);
			else if (frame_done && frame_cnt != '0)
				frame_cnt <= frame_cnt - 1'b1;
			// held at zero when the FIFO had no room, so the next frame retries
			case (state)
				IDLE:        state <= start ? HEADER : IDLE;
				HEADER:      state <= WORD_RED;
				WORD_RED:    state <= WORD_YELLOW;
				WORD_YELLOW: state <= WORD_TEAL;
				default:     state <= IDLE;
			endcase
		end
	end

	always_comb begin
		wr = (state != IDLE);
		case (state)
			HEADER:      wr_word = MSG_HEADER;
			WORD_RED:    wr_word = span_word(spans[RED]);
			WORD_YELLOW: wr_word = span_word(spans[YELLOW]);
			WORD_TEAL:   wr_word = span_word(spans[TEAL]);
			default:     wr_word = '0;
		endcase
	end

endmodule

/* logic/pixel_classify.sv */
// pixel classifier
// coordinates, HSV and colour windows

`timescale 1ns/1ps

module pixel_classify #(
	parameter int image_w = imgproc_pkg::IMAGE_W_DEF
) (
	input  logic clk,
	input  logic reset_n,
	input  logic advance,
	input  logic sink_valid,
	input  imgproc_pkg::pixel_t sink_pix,
	output logic cls_valid,
	output imgproc_pkg::classed_t cls
);
	import imgproc_pkg::*;

	logic [COORD_W-1:0] x_cnt, y_cnt;
	logic video;
	logic [7:0] hue, sat, val;
	colour_e hit;
	logic sop_video;

	function automatic logic in_window(input logic [7:0] h, s, v,
			input int lo, hi, smin, vmin);
		logic hue_ok;
		hue_ok = (lo <= hi) ? (h >= lo && h <= hi) : (h >= lo || h <= hi);
		return hue_ok && (s > smin) && (v > vmin);
	endfunction

	// six-sector hue, result halved to fit 0..179
	always_comb begin : hsv
		int r, g, b, mx, mn, d, deg;
		r = int'(sink_pix.rgb.r);
		g = int'(sink_pix.rgb.g);
		b = int'(sink_pix.rgb.b);
		mx = (r > g) ? ((r > b) ? r : b) : ((g > b) ? g : b);
		mn = (r < g) ? ((r < b) ? r : b) : ((g < b) ? g : b);
		d = mx - mn;
		val = 8'(mx);
		sat = (mx == 0) ? 8'd0 : 8'((d * 255) / mx);
		if (d == 0) begin
			deg = 0;
		end else if (mx == r) begin
			deg = (60 * (g - b)) / d;
			if (deg < 0)
				deg = deg + 360;
		end else if (mx == g) begin
			deg = 120 + (60 * (b - r)) / d;
		end else begin
			deg = 240 + (60 * (r - g)) / d;
		end
		hue = 8'(deg / 2);
	end

	// first window wins
	always_comb begin
		if (in_window(hue, sat, val, RED_HUE_LO, RED_HUE_HI, RED_SAT_MIN, RED_VAL_MIN))
			hit = RED;
		else if (in_window(hue, sat, val, YEL_HUE_LO, YEL_HUE_HI, YEL_SAT_MIN, YEL_VAL_MIN))
			hit = YELLOW;
		else if (in_window(hue, sat, val, TEAL_HUE_LO, TEAL_HUE_HI, TEAL_SAT_MIN, TEAL_VAL_MIN))
			hit = TEAL;
		else
			hit = NONE;
	end

	// video packets carry 0 in the low nibble of the descriptor
	assign sop_video = (sink_pix.rgb.b[3:0] == 4'h0);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cls_valid <= 1'b0;
			x_cnt <= '0;
			y_cnt <= '0;
			video <= 1'b0;
		end else if (advance) begin
			cls_valid <= sink_valid;
			if (sink_valid && sink_pix.sop) begin
				x_cnt <= '0;
				y_cnt <= '0;
				video <= sop_video;
			end else if (sink_valid) begin
				if (x_cnt == COORD_W'(image_w - 1)) begin
					x_cnt <= '0;
					y_cnt <= y_cnt + 1'b1;
				end else begin
					x_cnt <= x_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			cls.pix <= sink_pix;
			cls.x <= sink_pix.sop ? '0 : x_cnt;
			cls.y <= sink_pix.sop ? '0 : y_cnt;
			cls.is_video <= sink_pix.sop ? sop_video : video;
			cls.hit <= hit;
		end
	end

endmodule

/* project.f */
logic/imgproc_pkg.sv
logic/pixel_classify.sv
logic/colour_runs.sv
logic/frame_bounds.sv
logic/msg_writer.sv
logic/msg_fifo.sv
logic/csr_port.sv
logic/eee_imgproc.sv
test/imgproc_properties.sv
test/tb_eee_imgproc.sv

/* test/imgproc_properties.sv */
// stream and FIFO assertions

`timescale 1ns/1ps

module imgproc_properties (
	input logic clk,
	input logic reset_n,
	input logic source_valid,
	input logic source_ready,
	input imgproc_pkg::pixel_t source_pix,
	input logic fifo_wr,
	input logic [8:0] fifo_count
);
	import imgproc_pkg::*;

	int failures = 0;

	// stalled word holds
	stream_stable: assert property (@(posedge clk) disable iff (!reset_n)
		source_valid && !source_ready |=> source_valid && $stable(source_pix))
		else begin
			failures++;
			$error("source word changed while stalled");
		end

	no_write_when_full: assert property (@(posedge clk) disable iff (!reset_n)
		fifo_wr |-> fifo_count != 9'(FIFO_DEPTH))
		else begin
			failures++;
			$error("message write into a full FIFO");
		end

	valid_low_in_reset: assert property (@(posedge clk) !reset_n |=> !source_valid)
		else begin
			failures++;
			$error("source_valid high after reset");
		end

endmodule

bind eee_imgproc imgproc_properties i_imgproc_properties (
	.clk, .reset_n, .source_valid, .source_ready, .source_pix,
	.fifo_wr(msg_wr), .fifo_count
);

/* test/tb_eee_imgproc.sv */
// colour ball detector testbench

`timescale 1ns/1ps

module tb_eee_imgproc;
	import imgproc_pkg::*;

	localparam int IMG_W = 32;
	localparam int IMG_H = 8;
	localparam int HORIZON = 3;
	localparam int PIXELS = IMG_W * IMG_H;
	localparam int VIDEO_FRAMES = 14;
	localparam int FLUSH_FRAME = 7;
	localparam int CLK_PERIOD = 20;
	localparam logic [31:0] SEED = 32'hfa7d_e765;
	// twice frames x pixels x 8 cycles to allow for the short non-video packets
	localparam longint WATCHDOG_NS = longint'(2 * VIDEO_FRAMES) * (PIXELS + 1) * 8 * CLK_PERIOD;

	logic clk, reset_n, mode;
	logic sink_valid, sink_ready, source_valid, source_ready;
	pixel_t sink_pix, source_pix;
	logic s_chipselect, s_read, s_write;
	logic [2:0] s_address;
	logic [31:0] s_writedata, s_readdata;

	logic [31:0] rng, ready_rng;
	pixel_t exp_q [$];
	logic [31:0] msg_q [$];
	int run_cnt [1:3];
	logic [10:0] w_min [1:3];
	logic [10:0] w_max [1:3];
	int frame_gap;
	logic [7:0] status_low;
	int sent_count, rcv_count;

	eee_imgproc #(.image_w(IMG_W), .image_h(IMG_H), .horizon(HORIZON)) i_eee_imgproc (
		.clk, .reset_n, .mode, .sink_valid, .sink_ready, .sink_pix,
		.source_valid, .source_ready, .source_pix,
		.s_chipselect, .s_read, .s_write, .s_address, .s_writedata, .s_readdata
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////
	// helpers

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input logic [31:0] expected, input logic [31:0] actual,
			input string what);
		if (expected !== actual) begin
			$display("ERR at %0t ns: %s expected %08h got %08h", $time, what, expected, actual);
			abort_run();
		end
	endtask

	// base colour plus or minus 16
	function automatic logic [7:0] jitter(input int base);
		logic [31:0] rn;
		rn = next_rand();
		return 8'(base + int'(rn[4:0]) - 16);
	endfunction

	function automatic rgb_t pick_colour(input int kind);
		rgb_t c;
		logic [31:0] rn;
		case (kind)
			0: c = '{jitter(220), jitter(24), jitter(24)};
			1: c = '{jitter(220), jitter(200), jitter(24)};
			2: c = '{jitter(20), jitter(150), jitter(100)};
			default: begin
				rn = next_rand();
				c = rn[23:0];
			end
		endcase
		return c;
	endfunction

	//////////////////////////////
	// reference model

	// 0 none, 1 red, 2 yellow, 3 teal
	function automatic int classify(input rgb_t c);
		int r, g, b, mx, mn, d, h, s;
		r = c.r;
		g = c.g;
		b = c.b;
		mx = r;
		if (g > mx) mx = g;
		if (b > mx) mx = b;
		mn = r;
		if (g < mn) mn = g;
		if (b < mn) mn = b;
		d = mx - mn;
		s = (mx == 0) ? 0 : (d * 255) / mx;
		if (d == 0) begin
			h = 0;
		end else if (r == mx) begin
			h = (60 * (g - b)) / d;
			if (h < 0)
				h = h + 360;
		end else if (g == mx) begin
			h = 120 + (60 * (b - r)) / d;
		end else begin
			h = 240 + (60 * (r - g)) / d;
		end
		h = h / 2;
		if ((h <= 6 || h >= 172) && s > 84 && mx > 105)
			return 1;
		if (h >= 16 && h <= 30 && s > 127 && mx > 124)
			return 2;
		if (h >= 53 && h <= 85 && s > 80 && mx > 60)
			return 3;
		return 0;
	endfunction

	function automatic rgb_t marker(input int colour);
		case (colour)
			1: return 24'hff1000;
			2: return 24'hffff00;
			default: return 24'h008080;
		endcase
	endfunction

	function automatic rgb_t grey_of(input rgb_t c);
		logic [7:0] v;
		v = 8'(c.g / 2 + c.r / 4 + c.b / 4);
		return '{v, v, v};
	endfunction

	function automatic logic [31:0] status_word();
		return {16'b0, 8'(msg_q.size()), status_low & 8'hef};
	endfunction

	task automatic model_frame_end();
		if (frame_gap == 0) begin
			msg_q.push_back(32'h0052_4242);
			for (int c = 1; c <= 3; c++)
				msg_q.push_back({5'b0, w_min[c], 5'b0, w_max[c]});
			frame_gap = MSG_INTERVAL - 1;
		end else begin
			frame_gap--;
		end
	endtask

	// idx counts pixels after the sop word
	task automatic model_word(input pixel_t p, input logic video, input int idx);
		int hit;
		int conf;
		pixel_t e;
		hit = classify(p.rgb);
		conf = 0;
		e = p;
		if (p.sop) begin
			for (int c = 1; c <= 3; c++) begin
				run_cnt[c] = 0;
				w_min[c] = 11'(IMG_W - 1);
				w_max[c] = '0;
			end
		end else begin
			if (hit != 0 && run_cnt[hit] + 1 >= RUN_LEN)
				conf = hit;
			for (int c = 1; c <= 3; c++) begin
				if (c != hit)
					run_cnt[c] = 0;
				else if (run_cnt[c] < RUN_LEN)
					run_cnt[c] = run_cnt[c] + 1;
			end
			if (mode && video)
				e.rgb = (conf != 0) ? marker(conf) : grey_of(p.rgb);
			if (conf != 0 && idx / IMG_W > HORIZON) begin
				if (11'(idx % IMG_W) < w_min[conf])
					w_min[conf] = 11'(idx % IMG_W);
				if (11'(idx % IMG_W) > w_max[conf])
					w_max[conf] = 11'(idx % IMG_W);
			end
			if (p.eop && video)
				model_frame_end();
		end
		exp_q.push_back(e);
	endtask

	//////////////////////////////
	// stimulus

	task automatic send_word(input pixel_t p);
		logic sent;
		logic [31:0] rn;
		sent = 1'b0;
		while (!sent) begin
			rn = next_rand();
			sink_pix = p;
			sink_valid = (rn[1:0] != 2'b00);
			@(posedge clk);
			sent = sink_valid && sink_ready;
			#2;
		end
		sink_valid = 1'b0;
		sent_count++;
	endtask

	task automatic send_packet(input logic video);
		pixel_t p;
		logic [31:0] rn;
		int idx, len, kind, total;
		rn = next_rand();
		p = '0;
		p.rgb = rn[23:0];
		p.rgb.b[3:0] = video ? 4'h0 : (rn[27:24] | 4'h1);
		p.sop = 1'b1;
		model_word(p, video, 0);
		send_word(p);
		total = video ? PIXELS : 4 + int'(next_rand() % 29);
		idx = 0;
		while (idx < total) begin
			len = 1 + int'(next_rand() % 20);
			kind = int'(next_rand() % 4);
			for (int k = 0; k < len && idx < total; k++) begin
				p.rgb = pick_colour(kind);
				p.sop = 1'b0;
				p.eop = (idx == total - 1);
				model_word(p, video, idx);
				send_word(p);
				idx++;
			end
		end
	endtask

	// message writes land a few cycles after the eop leaves
	task automatic wait_drained();
		while (rcv_count != sent_count)
			@(posedge clk);
		repeat (8) @(posedge clk);
		#2;
	endtask

	task automatic csr_read(input logic [2:0] addr, output logic [31:0] data);
		@(posedge clk);
		#2;
		s_chipselect = 1'b1;
		s_read = 1'b1;
		s_address = addr;
		@(posedge clk);
		#2;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		data = s_readdata;
	endtask

	task automatic csr_write(input logic [2:0] addr, input logic [31:0] data);
		@(posedge clk);
		#2;
		s_chipselect = 1'b1;
		s_write = 1'b1;
		s_address = addr;
		s_writedata = data;
		@(posedge clk);
		#2;
		s_chipselect = 1'b0;
		s_write = 1'b0;
	endtask

	task automatic check_messages(input int frame_no);
		logic [31:0] rd;
		csr_read(STATUS, rd);
		check(status_word(), rd, "STATUS after frame");
		if (frame_no == FLUSH_FRAME) begin
			for (int k = 0; k < 2; k++) begin
				csr_read(MSG, rd);
				check(msg_q.pop_front(), rd, "message word");
			end
			csr_write(STATUS, 32'h0000_005b);
			status_low = 8'h5b;
			msg_q.delete();
			csr_read(STATUS, rd);
			check(status_word(), rd, "STATUS after flush");
		end else begin
			while (msg_q.size() != 0) begin
				csr_read(MSG, rd);
				check(msg_q.pop_front(), rd, "message word");
			end
		end
	endtask

	//////////////////////////////
	// output monitor samples mid-cycle

	always @(negedge clk) begin
		if (reset_n && source_valid && source_ready) begin
			if (exp_q.size() == 0) begin
				$display("an output word appeared at %0t ns with none expected", $time);
				abort_run();
			end else begin
				check(32'(exp_q.pop_front()), 32'(source_pix), "output pixel");
				rcv_count++;
			end
		end
	end

	// random back-pressure from its own generator
	initial begin
		ready_rng = xorshift32(SEED ^ 32'h5555_5555);
		forever begin
			@(posedge clk);
			#2;
			ready_rng = xorshift32(ready_rng);
			source_ready = (ready_rng[7:0] < 8'd192);
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Simulation finished: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [31:0] rd, rn;
		int video_frames;
		logic last_video;
		reset_n = 1'b0;
		mode = 1'b0;
		sink_valid = 1'b0;
		sink_pix = '0;
		source_ready = 1'b0;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		s_write = 1'b0;
		s_address = '0;
		s_writedata = '0;
		rng = SEED;
		frame_gap = 0;
		status_low = 8'h00;
		sent_count = 0;
		rcv_count = 0;
		video_frames = 0;
		last_video = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		reset_n = 1'b1;

		csr_read(ID, rd);
		check(32'h1234_eee2, rd, "ID register");
		// pop attempt on an empty FIFO
		csr_read(MSG, rd);
		csr_read(STATUS, rd);
		check(status_word(), rd, "STATUS after empty MSG read");

		while (video_frames < VIDEO_FRAMES) begin
			rn = next_rand();
			mode = rn[0];
			if (last_video && rn[2:1] == 2'b00) begin
				send_packet(1'b0);
				wait_drained();
				last_video = 1'b0;
			end else begin
				send_packet(1'b1);
				wait_drained();
				video_frames++;
				last_video = 1'b1;
				check_messages(video_frames);
			end
		end

		if (i_eee_imgproc.i_imgproc_properties.failures == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("%0d stream or FIFO assertions failed",
				i_eee_imgproc.i_imgproc_properties.failures);
			$display("Simulation finished: FAIL");
			$fatal(1, "assertion failures");
		end
	end

endmodule
